// ==== verilog.f ====
common/linkSpiPkg.sv
common/spiWordIf.sv
common/frameIf.sv
rtl/spiSlave.sv
linkSpi/frameDecoder.sv
linkSpi/frameChecksum.sv
linkSpi/frameCommit.sv
linkSpi/linkSpi.sv
verif/linkSpi_asserts.sv
verif/tb_linkSpi.sv

// ==== verif/tb_linkSpi.sv ====
`timescale 1ns/1ns

module tb_linkSpi import linkSpiPkg::*; ();

	localparam logic [7:0]  DEV_ADDR        = 8'hAB;
	localparam int          HALF_CYCLES     = 4;  // 32 ns SCK half period
	localparam int          NUM_FRAMES      = 17;
	localparam int          MAX_FRAME_WORDS = 20; // 16 data words plus overhead
	localparam int unsigned SEED            = 32'h06ef_166e;
	// frames x (words + 2) x 16 bits x 64 ns doubled and counted in 8 ns cycles
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * (MAX_FRAME_WORDS + 2) * 16 * 8 * 2;

	logic              clk;
	logic              rstN;
	logic              sck;
	logic              csN;
	logic              mosi;
	logic              miso;
	logic [WORD_W-1:0] pushData;
	logic              pushValid;
	logic [WORD_W-1:0] popData;
	logic              popEmpty;
	logic              popReq;
	logic [WORD_W-1:0] statusWord;
	logic              sysReset;
	logic              frameError;

	logic [WORD_W-1:0] frameWords [$]; // words the master sends
	logic [WORD_W-1:0] replyWords [$]; // words captured from MISO
	logic [WORD_W-1:0] expReply [$];
	logic [WORD_W-1:0] pushExpect [$];
	logic [WORD_W-1:0] popStore [$];   // external receive store model
	logic              popPending;
	int pushCount, popCount, resetCount, errorPulseCount;
	int pushBase, popBase, resetBase, errorBase;
	int checkCount, errorCount, cycleCount;

	linkSpi #(
		.DEVICE_ADDR (DEV_ADDR),
		.MAX_WORDS   (16)
	) u_linkSpi (
		.clk        (clk),
		.rstN       (rstN),
		.sck        (sck),
		.csN        (csN),
		.mosi       (mosi),
		.miso       (miso),
		.pushData   (pushData),
		.pushValid  (pushValid),
		.popData    (popData),
		.popEmpty   (popEmpty),
		.popReq     (popReq),
		.statusWord (statusWord),
		.sysReset   (sysReset),
		.frameError (frameError)
	);

	bind linkSpi linkSpi_asserts u_linkSpiAsserts (
		.clk        (clk),
		.rstN       (rstN),
		.pushValid  (pushValid),
		.popReq     (popReq),
		.popEmpty   (popEmpty),
		.sysReset   (sysReset),
		.frameError (frameError)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, the frames never completed", cycleCount);
			$display("** FAIL **");
			$finish;
		end
	end

	// outputs sampled mid-cycle
	always @(negedge clk)
	begin
		if (rstN)
		begin
			if (pushValid)
			begin
				pushCount++;
				if (pushExpect.size() == 0)
				begin
					errorCount++;
					$display("unexpected push of word %0h while nothing was queued", pushData);
				end
				else
					checkValue("push data", pushExpect.pop_front(), pushData);
			end
			popCount        += popReq;
			resetCount      += sysReset;
			errorPulseCount += frameError;
			popPending       = popReq;
		end
	end

	// show-ahead store advances after the edge that took the word
	always @(posedge clk)
	begin
		#1;
		if (popPending && popStore.size() != 0)
			popStore.delete(0);
		popPending = 1'b0;
		popEmpty   = (popStore.size() == 0);
		popData    = popEmpty ? '0 : popStore[0];
	end

	function automatic logic [WORD_W-1:0] randWord();
		logic [31:0] r;
		r = $urandom;
		return r[WORD_W-1:0];
	endfunction

	// expected checksum as the wrapping sum of the first count words
	function automatic logic [WORD_W-1:0] frameSum(input int count);
		logic [WORD_W-1:0] sum;
		sum = '0;
		for (int i = 0; i < count; i++)
			sum = sum + frameWords[i];
		return sum;
	endfunction

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			$display("[ERROR] %s expected %0h actual %0h", testName, expected, actual);
		end
	endtask

	task automatic waitCycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic markCounts();
		pushBase  = pushCount;
		popBase   = popCount;
		resetBase = resetCount;
		errorBase = errorPulseCount;
	endtask

	task automatic checkCounts(input string testName, input int pushes, input int pops,
		input int resets, input int errors);
		checkValue({testName, " pushes"}, pushes, pushCount - pushBase);
		checkValue({testName, " pops"}, pops, popCount - popBase);
		checkValue({testName, " resets"}, resets, resetCount - resetBase);
		checkValue({testName, " errors"}, errors, errorPulseCount - errorBase);
	endtask

	// mode 0 with MOSI set while SCK low and MISO taken before the rising edge
	task automatic shiftWord(input logic [WORD_W-1:0] txVal, output logic [WORD_W-1:0] rxVal);
		rxVal = '0;
		for (int i = WORD_W - 1; i >= 0; i--)
		begin
			sck  = 1'b0;
			mosi = txVal[i];
			waitCycles(HALF_CYCLES);
			rxVal[i] = miso;
			sck      = 1'b1;
			waitCycles(HALF_CYCLES);
		end
	endtask

	task automatic sendFrame();
		logic [WORD_W-1:0] rxVal;
		replyWords.delete();
		csN = 1'b0;
		waitCycles(HALF_CYCLES);
		foreach (frameWords[i])
		begin
			shiftWord(frameWords[i], rxVal);
			replyWords.push_back(rxVal);
		end
		sck = 1'b0;
		waitCycles(HALF_CYCLES);
		csN = 1'b1;
		waitCycles(4 * HALF_CYCLES); // gap between frames
		while (pushExpect.size() != 0)
			waitCycles(1); // drain empties the expected words
	endtask

	task automatic buildFrame(input logic [7:0] addr, input logic [7:0] cmd,
		input logic [7:0] n, input logic [WORD_W-1:0] sumDelta);
		logic [WORD_W-1:0] rw;
		frameWords.delete();
		expReply.delete();
		rw = randWord();
		frameWords.push_back({addr, rw[7:0]}); // low byte ignored
		frameWords.push_back({n, cmd});
		repeat (n)
			frameWords.push_back(randWord());
		frameWords.push_back(frameSum(frameWords.size()) + sumDelta);
		frameWords.push_back(randWord()); // trailer
		repeat (frameWords.size())
			expReply.push_back('0);
	endtask

	task automatic compareReplies(input string testName);
		foreach (expReply[i])
			checkValue({testName, " reply"}, expReply[i], replyWords[i]);
	endtask

	task automatic transmitFrames(input int count);
		logic [WORD_W-1:0] rw;
		logic [7:0]        n;
		repeat (count)
		begin
			rw = randWord();
			n  = {4'd0, rw[3:0]} + 8'd1; // 1 to 16 words
			buildFrame(DEV_ADDR, CMD_TRANSMIT, n, '0);
			for (int j = 0; j < n; j++)
				pushExpect.push_back(frameWords[2 + j]);
			markCounts();
			sendFrame();
			compareReplies("transmit");
			checkCounts("transmit", n, 0, 0, 0);
		end
	endtask

	task automatic statusFrame(input logic [7:0] n);
		statusWord = randWord();
		buildFrame(DEV_ADDR, CMD_STATUS, n, '0);
		for (int j = 0; j < n; j++)
			expReply[2 + j] = statusWord;
		markCounts();
		sendFrame();
		compareReplies("status");
		checkCounts("status", 0, 0, 0, 0);
	endtask

	task automatic receiveFrame(input logic [7:0] n, input int stored);
		int expPops;
		for (int i = 0; i < stored; i++)
			popStore.push_back(randWord());
		waitCycles(2); // store outputs settle
		buildFrame(DEV_ADDR, CMD_RECEIVE, n, '0);
		expPops = (popStore.size() < n) ? popStore.size() : n;
		for (int j = 0; j < expPops; j++)
			expReply[2 + j] = popStore[j]; // zeros remain once empty
		markCounts();
		sendFrame();
		compareReplies("receive");
		checkCounts("receive", 0, expPops, 0, 0);
	endtask

	task automatic foreignFrame(input logic [7:0] cmd, input logic [7:0] n);
		int storeBefore;
		storeBefore = popStore.size();
		buildFrame(8'h01, cmd, n, '0);
		markCounts();
		sendFrame();
		compareReplies("wrong address");
		checkCounts("wrong address", 0, 0, 0, 0);
		checkValue("wrong address store", storeBefore, popStore.size());
	endtask

	task automatic resetFrame(input logic [WORD_W-1:0] sumDelta);
		buildFrame(DEV_ADDR, CMD_RESET, 8'd0, sumDelta);
		markCounts();
		sendFrame();
		compareReplies("reset");
		if (sumDelta == '0)
			checkCounts("reset", 0, 0, 1, 0);
		else
			checkCounts("reset bad sum", 0, 0, 0, 1);
	endtask

	initial
	begin
		void'($urandom(SEED));
		rstN       = 1'b0;
		sck        = 1'b0;
		csN        = 1'b1;
		mosi       = 1'b0;
		statusWord = '0;
		popData    = '0;
		popEmpty   = 1'b1;
		popPending = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;
		waitCycles(2);

		transmitFrames(6);
		statusFrame(8'd3);
		statusFrame(8'd16);
		receiveFrame(8'd5, 3);
		receiveFrame(8'd2, 4); // leaves two words behind
		foreignFrame(CMD_TRANSMIT, 8'd3);
		foreignFrame(CMD_RESET, 8'd0);
		foreignFrame(CMD_STATUS, 8'd2);
		foreignFrame(CMD_RECEIVE, 8'd2);

		buildFrame(DEV_ADDR, CMD_TRANSMIT, 8'd4, 16'h0001); // sum off by one
		markCounts();
		sendFrame();
		compareReplies("bad checksum");
		checkCounts("bad checksum", 0, 0, 0, 1);

		resetFrame('0);
		resetFrame(16'h0100);

		$display("checks %0d errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== verif/linkSpi_asserts.sv ====
`timescale 1ns/1ns

module linkSpi_asserts (
	input logic clk,
	input logic rstN,
	input logic pushValid,
	input logic popReq,
	input logic popEmpty,
	input logic sysReset,
	input logic frameError
);

	// a commit drains or resets but never both
	noPushDuringReset: assert property (@(posedge clk) disable iff (!rstN)
		!(pushValid && sysReset))
		else $error("pushValid and sysReset high together");

	popOnlyWhenFull: assert property (@(posedge clk) disable iff (!rstN)
		popReq |-> !popEmpty)
		else $error("popReq while the store is empty");

	resetSinglePulse: assert property (@(posedge clk) disable iff (!rstN)
		sysReset |=> !sysReset)
		else $error("sysReset longer than one cycle");

	errorSinglePulse: assert property (@(posedge clk) disable iff (!rstN)
		frameError |=> !frameError)
		else $error("frameError longer than one cycle");

	// first cycle out of reset
	quietAfterReset: assert property (@(posedge clk)
		$rose(rstN) |-> !pushValid && !popReq && !sysReset && !frameError)
		else $error("control output high right after reset");

endmodule

// ==== linkSpi/linkSpi.sv ====
`timescale 1ns/1ns

module linkSpi import linkSpiPkg::*; #(
	parameter logic [7:0] DEVICE_ADDR = 8'hAB,
	parameter int         MAX_WORDS   = 16
) (
	input  logic              clk,
	input  logic              rstN,
	input  logic              sck,
	input  logic              csN,
	input  logic              mosi,
	output logic              miso,
	output logic [WORD_W-1:0] pushData,
	output logic              pushValid,
	input  logic [WORD_W-1:0] popData,
	input  logic              popEmpty,
	output logic              popReq,
	input  logic [WORD_W-1:0] statusWord,
	output logic              sysReset,
	output logic              frameError
);

	logic sumDone;
	logic sumOk;

	spiWordIf wordBus ();  // SPI slave to decoder and reply path
	frameIf   frameBus (); // decoded words to checksum and commit

	spiSlave u_spiSlave (
		.clk      (clk),
		.rstN     (rstN),
		.sck      (sck),
		.csN      (csN),
		.mosi     (mosi),
		.miso     (miso),
		.wordPort (wordBus.slave)
	);

	frameDecoder #(
		.DEVICE_ADDR (DEVICE_ADDR)
	) u_frameDecoder (
		.clk      (clk),
		.rstN     (rstN),
		.wordPort (wordBus.decoder),
		.frame    (frameBus.source)
	);

	frameChecksum u_frameChecksum (
		.clk     (clk),
		.rstN    (rstN),
		.frame   (frameBus.checksum),
		.sumDone (sumDone),
		.sumOk   (sumOk)
	);

	frameCommit #(
		.MAX_WORDS (MAX_WORDS)
	) u_frameCommit (
		.clk        (clk),
		.rstN       (rstN),
		.frame      (frameBus.committer),
		.replyPort  (wordBus.reply),
		.sumDone    (sumDone),
		.sumOk      (sumOk),
		.pushData   (pushData),
		.pushValid  (pushValid),
		.popData    (popData),
		.popEmpty   (popEmpty),
		.popReq     (popReq),
		.statusWord (statusWord),
		.sysReset   (sysReset),
		.frameError (frameError)
	);

endmodule

// ==== linkSpi/frameCommit.sv ====
`timescale 1ns/1ns

module frameCommit import linkSpiPkg::*; #(
	parameter int MAX_WORDS = 16
) (
	input  logic              clk,
	input  logic              rstN,
	frameIf.committer         frame,
	spiWordIf.reply           replyPort,
	input  logic              sumDone,
	input  logic              sumOk,
	output logic [WORD_W-1:0] pushData,
	output logic              pushValid,
	input  logic [WORD_W-1:0] popData,
	input  logic              popEmpty,
	output logic              popReq,
	input  logic [WORD_W-1:0] statusWord,
	output logic              sysReset,
	output logic              frameError
);

	localparam int PTR_W = (MAX_WORDS > 1) ? $clog2(MAX_WORDS) : 1;

	logic [WORD_W-1:0] txBuf [MAX_WORDS]; // A2 data waiting for the checksum
	logic [PTR_W-1:0]  rdPtr;
	logic [7:0]        drainLeft;
	logic              draining;
	logic              isTransmit;
	logic              tooBig;
	logic              commitOk;   // good checksum on an addressed frame
	logic              startDrain;
	logic              nextIsData; // the following slot carries data
	logic [WORD_W-1:0] replyNext;

	assign isTransmit = (frame.cmd == CMD_TRANSMIT);
	assign tooBig     = (frame.size > MAX_WORDS);
	assign commitOk   = sumDone && frame.addrMatch && sumOk;
	assign startDrain = commitOk && isTransmit && !tooBig && frame.size != 8'd0;

	assign nextIsData = (frame.slot == SLOT_SIZE_CMD && frame.size != 8'd0) ||
		(frame.slot == SLOT_DATA && ({1'b0, frame.dataIndex} + 9'd1 < {1'b0, frame.size}));

	// one word per cycle once the frame is committed
	assign pushValid = draining;
	assign pushData  = txBuf[rdPtr];

	// show-ahead store gives up its word in the same cycle
	assign popReq = frame.wordValid && frame.addrMatch && nextIsData &&
		frame.cmd == CMD_RECEIVE && !popEmpty;

	always_comb
	begin
		replyNext = '0;
		if (frame.addrMatch && nextIsData)
		begin
			case (frame.cmd)
				CMD_STATUS:  replyNext = statusWord;
				CMD_RECEIVE: replyNext = popEmpty ? '0 : popData; // zero when store is empty
				default:     replyNext = '0;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (frame.wordValid && frame.addrMatch && isTransmit &&
			frame.slot == SLOT_DATA && frame.dataIndex < MAX_WORDS)
			txBuf[frame.dataIndex[PTR_W-1:0]] <= frame.word;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			draining           <= 1'b0;
			rdPtr              <= '0;
			drainLeft          <= '0;
			sysReset           <= 1'b0;
			frameError         <= 1'b0;
			replyPort.txWord   <= '0;
		end
		else
		begin
			sysReset   <= commitOk && frame.cmd == CMD_RESET;
			frameError <= sumDone && frame.addrMatch && (!sumOk || (isTransmit && tooBig));

			if (startDrain)
			begin
				draining  <= 1'b1;
				rdPtr     <= '0;
				drainLeft <= frame.size;
			end
			else if (draining)
			begin
				rdPtr     <= rdPtr + 1'b1;
				drainLeft <= drainLeft - 8'd1;
				if (drainLeft == 8'd1)
					draining <= 1'b0; // last word goes out this cycle
			end

			if (frame.wordValid)
				replyPort.txWord <= replyNext; // zero outside the data slots
		end
	end

endmodule

// ==== linkSpi/frameChecksum.sv ====
`timescale 1ns/1ns

module frameChecksum import linkSpiPkg::*; (
	input  logic     clk,
	input  logic     rstN,
	frameIf.checksum frame,
	output logic     sumDone,
	output logic     sumOk
);

	logic [WORD_W-1:0] sum; // wrapping sum of the words so far

	always_ff @(posedge clk)
	begin
		if (frame.wordValid)
		begin
			case (frame.slot)
				SLOT_ADDR:                sum <= frame.word; // start of frame
				SLOT_SIZE_CMD, SLOT_DATA: sum <= sum + frame.word;
				default:                  sum <= sum;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			sumDone <= 1'b0;
			sumOk   <= 1'b0;
		end
		else
		begin
			sumDone <= 1'b0;
			if (frame.wordValid && frame.slot == SLOT_CHECKSUM)
			begin
				sumDone <= 1'b1;
				sumOk   <= (frame.word == sum);
			end
		end
	end

endmodule

// ==== linkSpi/frameDecoder.sv ====
`timescale 1ns/1ns

module frameDecoder import linkSpiPkg::*; #(
	parameter logic [7:0] DEVICE_ADDR = 8'hAB
) (
	input  logic        clk,
	input  logic        rstN,
	spiWordIf.decoder   wordPort,
	frameIf.source      frame
);

	slot_e      nextSlot;   // slot expected for the next word
	slot_e      curSlot;
	logic       csPrev;
	logic       frameStart; // next word opens a frame
	logic [7:0] dataCnt;

	assign curSlot = frameStart ? SLOT_ADDR : nextSlot;

	always_ff @(posedge clk)
	begin
		if (wordPort.rxValid)
			frame.word <= wordPort.rxWord;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			nextSlot        <= SLOT_ADDR;
			csPrev          <= 1'b0;
			frameStart      <= 1'b1;
			dataCnt         <= '0;
			frame.wordValid <= 1'b0;
			frame.slot      <= SLOT_ADDR;
			frame.cmd       <= CMD_STATUS;
			frame.size      <= '0;
			frame.addrMatch <= 1'b0;
			frame.dataIndex <= '0;
		end
		else
		begin
			csPrev          <= wordPort.csActive;
			frame.wordValid <= wordPort.rxValid;

			if (wordPort.rxValid)
				frameStart <= 1'b0;
			else if (wordPort.csActive && !csPrev)
				frameStart <= 1'b1; // new chip select restarts the frame

			if (wordPort.rxValid)
			begin
				frame.slot      <= curSlot;
				frame.dataIndex <= dataCnt;
				case (curSlot)
					SLOT_ADDR:
					begin
						frame.addrMatch <= (wordPort.rxWord[15:8] == DEVICE_ADDR);
						nextSlot        <= SLOT_SIZE_CMD;
					end
					SLOT_SIZE_CMD:
					begin
						frame.size <= wordPort.rxWord[15:8];
						frame.cmd  <= cmd_e'(wordPort.rxWord[7:0]);
						dataCnt    <= '0;
						nextSlot   <= (wordPort.rxWord[15:8] == 8'd0) ? SLOT_CHECKSUM : SLOT_DATA;
					end
					SLOT_DATA:
					begin
						dataCnt  <= dataCnt + 8'd1;
						nextSlot <= (dataCnt + 8'd1 == frame.size) ? SLOT_CHECKSUM : SLOT_DATA;
					end
					SLOT_CHECKSUM:
						nextSlot <= SLOT_TRAILER;
					default:
						nextSlot <= SLOT_ADDR; // trailer closes the frame
				endcase
			end
		end
	end

endmodule

// ==== rtl/spiSlave.sv ====
`timescale 1ns/1ns

module spiSlave import linkSpiPkg::*; (
	input  logic     clk,
	input  logic     rstN,
	input  logic     sck,
	input  logic     csN,
	input  logic     mosi,
	output logic     miso,
	spiWordIf.slave  wordPort
);

	logic [2:0]        sckSync;  // two sync stages plus previous value
	logic [1:0]        mosiSync;
	logic [1:0]        csSync;
	logic              sckRise;
	logic              sckFall;
	logic [3:0]        bitCnt;   // bits received in the current word
	logic [WORD_W-1:0] rxShift;
	logic [WORD_W-1:0] txShift;
	logic [1:0]        loadDly;  // waits for the reply to settle

	assign sckRise = sckSync[1] & ~sckSync[2];
	assign sckFall = ~sckSync[1] & sckSync[2];

	assign wordPort.csActive = ~csSync[1];
	assign wordPort.rxWord   = rxShift;
	assign miso              = txShift[WORD_W-1]; // MSB first

	always_ff @(posedge clk)
	begin
		if (sckRise)
			rxShift <= {rxShift[WORD_W-2:0], mosiSync[1]};
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			sckSync          <= '0;
			mosiSync         <= '0;
			csSync           <= '1;
			bitCnt           <= '0;
			wordPort.rxValid <= 1'b0;
			loadDly          <= '0;
			txShift          <= '0;
		end
		else
		begin
			sckSync          <= {sckSync[1:0], sck};
			mosiSync         <= {mosiSync[0], mosi};
			csSync           <= {csSync[0], csN};
			wordPort.rxValid <= 1'b0;
			loadDly          <= {loadDly[0], wordPort.rxValid};

			if (!wordPort.csActive)
			begin
				bitCnt  <= '0; // released between frames
				txShift <= '0;
			end
			else if (sckRise)
			begin
				bitCnt <= bitCnt + 4'd1; // wraps after 16 bits
				if (bitCnt == 4'd15)
					wordPort.rxValid <= 1'b1;
			end
			else if (sckFall && bitCnt != 4'd0)
				txShift <= {txShift[WORD_W-2:0], 1'b0}; // skip the trailing fall
			else if (loadDly[1])
				txShift <= wordPort.txWord; // reply is ready two cycles after rxValid
		end
	end

endmodule

// ==== common/frameIf.sv ====
`timescale 1ns/1ns

interface frameIf import linkSpiPkg::*; ();

	logic [WORD_W-1:0] word;      // raw frame word
	logic              wordValid; // one pulse per word
	slot_e             slot;      // slot this word belongs to
	cmd_e              cmd;       // opcode of the current frame
	logic [7:0]        size;      // number of data words
	logic              addrMatch; // frame is addressed to this device
	logic [7:0]        dataIndex; // position within the data slots

	modport source
	(
		output word, wordValid, slot, cmd, size, addrMatch, dataIndex
	);

	modport checksum
	(
		input word, wordValid, slot
	);

	modport committer
	(
		input word, wordValid, slot, cmd, size, addrMatch, dataIndex
	);

endinterface

// ==== common/spiWordIf.sv ====
`timescale 1ns/1ns

interface spiWordIf import linkSpiPkg::*; ();

	logic [WORD_W-1:0] rxWord;   // last completed word from the host
	logic              rxValid;  // one pulse per completed word
	logic              csActive; // chip select asserted, synchronized
	logic [WORD_W-1:0] txWord;   // reply shifted out during the next word

	modport slave
	(
		output rxWord,
		output rxValid,
		output csActive,
		input  txWord
	);

	modport decoder
	(
		input rxWord,
		input rxValid,
		input csActive
	);

	modport reply
	(
		output txWord
	);

endinterface

// ==== common/linkSpiPkg.sv ====
package linkSpiPkg;

	// every SPI transfer carries one word of this width
	localparam int WORD_W = 16;

	// opcode in the low byte of the size/command word
	typedef enum logic [7:0]
	{
		CMD_RESET    = 8'hA0, // system reset
		CMD_TRANSMIT = 8'hA2, // queue data words toward the 1553 side
		CMD_STATUS   = 8'hB0, // answer each data slot with the status word
		CMD_RECEIVE  = 8'hB2  // answer each data slot with a popped word
	} cmd_e;

	// position of a word inside a frame
	typedef enum logic [2:0]
	{
		SLOT_ADDR,     // device address in the high byte
		SLOT_SIZE_CMD, // data word count and opcode
		SLOT_DATA,
		SLOT_CHECKSUM, // wrapping sum of all earlier words
		SLOT_TRAILER   // ignored
	} slot_e;

endpackage
